// File: tb.f
dme_pkg.sv
tlb.sv
stb.sv
dca.sv
dme.sv
tb_dme.sv

// File: Bender.yml
package:
  name: dme

sources:
  - dme_pkg.sv
  - tlb.sv
  - stb.sv
  - dca.sv
  - dme.sv
  - target: test
    files:
      - tb_dme.sv

// File: tb_dme.sv
`timescale 1ns/1ns

module tb_dme;

    localparam logic [19:0] VPAGE = 20'h12345;
    localparam logic [19:0] PPAGE = 20'h00001;

    logic                  clk;
    logic                  i_reset;
    dme_pkg::mem_control_t i_control;
    logic [31:0]           i_virtual_addr;
    logic [31:0]           i_write_data;
    logic                  i_write_enable;
    logic [31:0]           i_physical_addr;
    logic                  i_mem_enable;
    logic [127:0]          i_mem_data;
    logic [31:0]           o_data_loaded;
    logic                  o_exception;
    logic                  o_stall;
    logic                  o_mem_enable;
    logic                  o_mem_write;
    logic [31:0]           o_mem_addr;
    logic [31:0]           o_mem_data;
    logic [3:0]            o_mem_strobe;

    logic [31:0] mem     [2048];    // Word index is pa[12:2].
    logic [31:0] ref_mem [2048];
    logic [31:0] lfsr_state;
    logic [31:0] wr_addr_q [$];
    logic [31:0] wr_data_q [$];
    logic [3:0]  wr_strb_q [$];
    int          req_count;
    int          rd_wait;
    logic [8:0]  rd_line;

    dme #(
        .TLB_LINES   (4),
        .STB_LINES   (4),
        .CACHE_LINES (8),
        .CACHE_BYTES (16),
        .REG_WIDTH   (32),
        .VA_WIDTH    (32),
        .PA_WIDTH    (32)
    ) uut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Memory model that answers line reads three edges after the request.
    always @(posedge clk) begin
        i_mem_enable <= 1'b0;
        if (rd_wait > 0) begin
            rd_wait--;
            if (rd_wait == 0) begin
                i_mem_enable <= 1'b1;
                for (int w = 0; w < 4; w++) i_mem_data[32 * w +: 32] <= mem[{rd_line, 2'(w)}];
            end
        end
        if (o_mem_enable === 1'b1) begin
            req_count++;
            if (o_mem_write) begin
                wr_addr_q.push_back(o_mem_addr);
                wr_data_q.push_back(o_mem_data);
                wr_strb_q.push_back(o_mem_strobe);
                for (int b = 0; b < 4; b++) begin
                    if (o_mem_strobe[b]) begin
                        mem[o_mem_addr[12:2]][8 * b +: 8] <= o_mem_data[8 * b +: 8];
                    end
                end
            end else begin
                rd_wait = 3;
                rd_line = o_mem_addr[12:4];
            end
        end
    end

    function automatic logic [31:0] next_word();
        logic [31:0] w;
        logic        fb;
        for (int i = 0; i < 32; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            w[i]       = fb;                    // One step per bit.
        end
        return w;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    function automatic dme_pkg::mem_control_t make_ctrl(input logic ld, input logic st,
            input dme_pkg::mem_size_e size, input logic uns);
        dme_pkg::mem_control_t c;
        c.is_load      = ld;
        c.is_store     = st;
        c.size         = size;
        c.use_unsigned = uns;
        return c;
    endfunction

    // Expected load value from a memory word.
    function automatic logic [31:0] extend_load(input logic [31:0] word, input logic [1:0] off,
            input dme_pkg::mem_size_e size, input logic uns);
        logic [31:0] sh;
        sh = word >> (8 * off);
        if (size == dme_pkg::SIZE_BYTE) return {{24{sh[7] & !uns}}, sh[7:0]};
        if (size == dme_pkg::SIZE_HALF) return {{16{sh[15] & !uns}}, sh[15:0]};
        return sh;
    endfunction

    task automatic store_ref(input logic [31:0] pa, input logic [31:0] wd,
            input dme_pkg::mem_size_e size);
        logic [3:0] lanes;
        lanes = (size == dme_pkg::SIZE_BYTE) ? 4'h1 : (size == dme_pkg::SIZE_HALF) ? 4'h3 : 4'hf;
        lanes = lanes << pa[1:0];
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) ref_mem[pa[12:2]][8 * b +: 8] = wd[8 * (b - pa[1:0]) +: 8];
        end
    endtask

    // Presents one operation and returns at the negedge before the completing edge.
    task automatic run_op(input dme_pkg::mem_control_t ctrl, input logic [11:0] off,
            input logic [31:0] wd, input logic fault, output logic [31:0] rdata,
            output int stalls);
        @(posedge clk);
        i_control      <= ctrl;
        i_virtual_addr <= {VPAGE, off};
        i_write_data   <= wd;
        stalls = 0;
        @(negedge clk);
        while (o_stall) begin
            stalls++;
            if (stalls == 100) begin
                $display("Timeout: o_stall stayed high for 100 cycles at offset %h", off);
                $display("*** FAILED ***");
                $fatal(1);
            end
            @(negedge clk);
        end
        expect_equal("o_exception", 32'(o_exception), 32'(fault));
        rdata = o_data_loaded;
        if (ctrl.is_store && !fault) store_ref({PPAGE, off}, wd, ctrl.size);
    endtask

    task automatic go_idle(input int cycles);
        @(posedge clk);
        i_control <= '0;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic load_word(input logic [11:0] off, output logic [31:0] rdata, output int stalls);
        run_op(make_ctrl(1'b1, 1'b0, dme_pkg::SIZE_WORD, 1'b0), off, '0, 1'b0, rdata, stalls);
    endtask

    task automatic expect_write(input logic [31:0] addr, input logic [31:0] data,
            input logic [3:0] strb);
        int cycles;
        cycles = 0;
        while (wr_addr_q.size() == 0) begin
            @(negedge clk);
            cycles++;
            if (cycles == 100) begin
                $display("Timeout: no memory write arrived for address %h", addr);
                $display("*** FAILED ***");
                $fatal(1);
            end
        end
        expect_equal("o_mem_addr", wr_addr_q.pop_front(), addr);
        expect_equal("o_mem_data", wr_data_q.pop_front(), data);
        expect_equal("o_mem_strobe", 32'(wr_strb_q.pop_front()), 32'(strb));
    endtask

    task automatic tlb_fault_then_fill;
        logic [31:0] d;
        int          s;
        run_op(make_ctrl(1'b1, 1'b0, dme_pkg::SIZE_WORD, 1'b0), 12'h040, '0, 1'b1, d, s);
        go_idle(3);
        expect_equal("memory requests", 32'(req_count), 0);
        i_write_enable  <= 1'b1;
        i_virtual_addr  <= {VPAGE, 12'h000};
        i_physical_addr <= {PPAGE, 12'h000};
        @(posedge clk);
        i_write_enable <= 1'b0;
        load_word(12'h040, d, s);
        expect_equal("o_data_loaded", d, ref_mem[{1'b1, 10'h010}]);
    endtask

    task automatic load_miss_then_hit;
        logic [31:0] d;
        int          s;
        load_word(12'h080, d, s);
        expect_equal("o_data_loaded", d, ref_mem[{1'b1, 10'h020}]);
        expect_equal("miss stalled", 32'(s != 0), 1);
        load_word(12'h08c, d, s);
        expect_equal("o_data_loaded", d, ref_mem[{1'b1, 10'h023}]);
        expect_equal("hit stall cycles", 32'(s), 0);
    endtask

    task automatic sign_zero_extension;
        logic [31:0] d;
        int          s;
        // Known bytes and halves with both sign bit values.
        run_op(make_ctrl(1'b0, 1'b1, dme_pkg::SIZE_WORD, 1'b0), 12'h084, 32'h7f80ff01, 1'b0,
            d, s);
        run_op(make_ctrl(1'b0, 1'b1, dme_pkg::SIZE_WORD, 1'b0), 12'h088, 32'h80007fff, 1'b0,
            d, s);
        go_idle(0);
        expect_write({PPAGE, 12'h084}, 32'h7f80ff01, 4'hf);
        expect_write({PPAGE, 12'h088}, 32'h80007fff, 4'hf);
        for (int u = 0; u < 2; u++) begin
            for (int b = 0; b < 4; b++) begin
                run_op(make_ctrl(1'b1, 1'b0, dme_pkg::SIZE_BYTE, u[0]), 12'(12'h084 + b), '0,
                    1'b0, d, s);
                expect_equal("byte load", d, extend_load(ref_mem[{1'b1, 10'h021}], 2'(b),
                    dme_pkg::SIZE_BYTE, u[0]));
            end
            for (int h = 0; h < 4; h += 2) begin
                run_op(make_ctrl(1'b1, 1'b0, dme_pkg::SIZE_HALF, u[0]), 12'(12'h088 + h), '0,
                    1'b0, d, s);
                expect_equal("half load", d, extend_load(ref_mem[{1'b1, 10'h022}], 2'(h),
                    dme_pkg::SIZE_HALF, u[0]));
            end
        end
    endtask

    task automatic store_forwarding;
        logic [31:0] wd;
        logic [31:0] d;
        int          s;
        wd = next_word();
        run_op(make_ctrl(1'b0, 1'b1, dme_pkg::SIZE_WORD, 1'b0), 12'h100, wd, 1'b0, d, s);
        load_word(12'h100, d, s);
        expect_equal("forwarded data", d, wd);
        expect_equal("forward stall cycles", 32'(s), 0);
        go_idle(0);
        expect_write({PPAGE, 12'h100}, wd, 4'hf);
    endtask

    task automatic fill_store_buffer;
        logic [11:0] offs [5];
        logic [31:0] wds  [5];
        logic [31:0] d;
        int          s;
        int          stalled;
        offs[0] = 12'h200;
        offs[1] = 12'h204;
        offs[2] = 12'h300;
        offs[3] = 12'h310;
        offs[4] = 12'h404;
        stalled = 0;
        for (int i = 0; i < 5; i++) begin
            wds[i] = next_word();
            run_op(make_ctrl(1'b0, 1'b1, dme_pkg::SIZE_WORD, 1'b0), offs[i], wds[i], 1'b0, d, s);
            stalled += s;
        end
        expect_equal("full buffer stalled", 32'(stalled != 0), 1);
        go_idle(0);
        for (int i = 0; i < 5; i++) expect_write({PPAGE, offs[i]}, wds[i], 4'hf);
        for (int i = 0; i < 5; i++) begin
            load_word(offs[i], d, s);
            expect_equal("reloaded data", d, wds[i]);
        end
    endtask

    task automatic partial_overlap;
        logic [31:0] d;
        int          s;
        run_op(make_ctrl(1'b0, 1'b1, dme_pkg::SIZE_BYTE, 1'b0), 12'h501, 32'h000000a5, 1'b0,
            d, s);
        load_word(12'h500, d, s);
        expect_equal("merged word", d, ref_mem[{1'b1, 10'h140}]);
        expect_equal("overlap stalled", 32'(s != 0), 1);
        go_idle(0);
        expect_write({PPAGE, 12'h500}, 32'h0000a500, 4'b0010);
    endtask

    initial begin
        i_reset         = 1'b1;
        i_control       = '0;
        i_virtual_addr  = '0;
        i_write_data    = '0;
        i_write_enable  = 1'b0;
        i_physical_addr = '0;
        i_mem_enable    = 1'b0;
        i_mem_data      = '0;
        req_count       = 0;
        rd_wait         = 0;
        lfsr_state      = 32'h453779e9;
        for (int i = 0; i < 2048; i++) begin
            mem[i] = next_word();
        end
        ref_mem = mem;
        repeat (10) @(posedge clk);
        i_reset <= 1'b0;
        tlb_fault_then_fill();
        load_miss_then_hit();
        sign_zero_extension();
        store_forwarding();
        fill_store_buffer();
        partial_overlap();
        go_idle(2);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: dme.sv
`timescale 1ns/1ns

module dme #(
    parameter int TLB_LINES   = 4,
    parameter int STB_LINES   = 4,
    parameter int CACHE_LINES = 8,
    parameter int CACHE_BYTES = 16,
    parameter int REG_WIDTH   = 32,
    parameter int VA_WIDTH    = 32,
    parameter int PA_WIDTH    = 32
) (
    input  logic                       clk,
    input  logic                       i_reset,
    input  dme_pkg::mem_control_t      i_control,
    input  logic [VA_WIDTH-1:0]        i_virtual_addr,
    input  logic [REG_WIDTH-1:0]       i_write_data,
    input  logic                       i_write_enable,
    input  logic [PA_WIDTH-1:0]        i_physical_addr,
    input  logic                       i_mem_enable,
    input  logic [CACHE_BYTES*8-1:0]   i_mem_data,
    output logic [REG_WIDTH-1:0]       o_data_loaded,
    output logic                       o_exception,
    output logic                       o_stall,
    output logic                       o_mem_enable,
    output logic                       o_mem_write,
    output logic [PA_WIDTH-1:0]        o_mem_addr,
    output logic [REG_WIDTH-1:0]       o_mem_data,
    output logic [REG_WIDTH/8-1:0]     o_mem_strobe
);

    logic [PA_WIDTH-1:0]    tlb_pa;
    logic                   tlb_miss;
    dme_pkg::mem_control_t  ctrl_q;     // Operation with faults removed.
    logic                   stb_push;
    logic                   stb_stall;
    logic                   stb_hit;
    logic [REG_WIDTH-1:0]   stb_data;
    logic                   drain;
    logic [PA_WIDTH-1:0]    drain_addr;
    logic [REG_WIDTH-1:0]   drain_data;
    logic [REG_WIDTH/8-1:0] drain_strobe;
    logic                   drain_ready;
    logic                   cache_stall;
    logic [REG_WIDTH-1:0]   cache_data;

    // A miss only faults when there is an access to translate.
    assign o_exception = tlb_miss && (i_control.is_load || i_control.is_store);

    always_comb begin
        ctrl_q          = i_control;
        ctrl_q.is_load  = i_control.is_load && !o_exception;
        ctrl_q.is_store = i_control.is_store && !o_exception;
    end

    assign stb_push      = ctrl_q.is_store && !o_stall;
    assign o_stall       = stb_stall || cache_stall;
    assign o_data_loaded = stb_hit ? stb_data : cache_data;

    tlb #(
        .N_LINES  (TLB_LINES),
        .VA_WIDTH (VA_WIDTH),
        .PA_WIDTH (PA_WIDTH)
    ) u_tlb (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_write_enable  (i_write_enable),
        .i_virtual_addr  (i_virtual_addr),
        .i_physical_addr (i_physical_addr),
        .o_physical_addr (tlb_pa),
        .o_exception     (tlb_miss)
    );

    stb #(
        .N_LINES   (STB_LINES),
        .PA_WIDTH  (PA_WIDTH),
        .REG_WIDTH (REG_WIDTH)
    ) u_stb (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_push         (stb_push),
        .i_control      (ctrl_q),
        .i_pa           (tlb_pa),
        .i_write_data   (i_write_data),
        .i_load         (ctrl_q.is_load),
        .i_drain_ready  (drain_ready),
        .o_full_stall   (stb_stall),
        .o_hit          (stb_hit),
        .o_read_data    (stb_data),
        .o_drain        (drain),
        .o_drain_addr   (drain_addr),
        .o_drain_data   (drain_data),
        .o_drain_strobe (drain_strobe)
    );

    dca #(
        .N_LINES   (CACHE_LINES),
        .N_BYTES   (CACHE_BYTES),
        .PA_WIDTH  (PA_WIDTH),
        .REG_WIDTH (REG_WIDTH)
    ) u_dca (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_load         (ctrl_q.is_load),
        .i_control      (ctrl_q),
        .i_pa           (tlb_pa),
        .i_stb_hit      (stb_hit),
        .i_drain        (drain),
        .i_drain_addr   (drain_addr),
        .i_drain_data   (drain_data),
        .i_drain_strobe (drain_strobe),
        .i_mem_enable   (i_mem_enable),
        .i_mem_data     (i_mem_data),
        .o_stall        (cache_stall),
        .o_read_data    (cache_data),
        .o_drain_ready  (drain_ready),
        .o_mem_enable   (o_mem_enable),
        .o_mem_write    (o_mem_write),
        .o_mem_addr     (o_mem_addr),
        .o_mem_data     (o_mem_data),
        .o_mem_strobe   (o_mem_strobe)
    );

endmodule

// File: dca.sv
`timescale 1ns/1ns

module dca #(
    parameter int N_LINES   = 8,
    parameter int N_BYTES   = 16,
    parameter int PA_WIDTH  = 32,
    parameter int REG_WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     i_reset,
    input  logic                     i_load,
    input  dme_pkg::mem_control_t    i_control,
    input  logic [PA_WIDTH-1:0]      i_pa,
    input  logic                     i_stb_hit,
    input  logic                     i_drain,
    input  logic [PA_WIDTH-1:0]      i_drain_addr,
    input  logic [REG_WIDTH-1:0]     i_drain_data,
    input  logic [REG_WIDTH/8-1:0]   i_drain_strobe,
    input  logic                     i_mem_enable,
    input  logic [N_BYTES*8-1:0]     i_mem_data,
    output logic                     o_stall,
    output logic [REG_WIDTH-1:0]     o_read_data,
    output logic                     o_drain_ready,
    output logic                     o_mem_enable,
    output logic                     o_mem_write,
    output logic [PA_WIDTH-1:0]      o_mem_addr,
    output logic [REG_WIDTH-1:0]     o_mem_data,
    output logic [REG_WIDTH/8-1:0]   o_mem_strobe
);

    localparam int LINE_W = N_BYTES * 8;
    localparam int NB     = REG_WIDTH / 8;
    localparam int BOFF_W = $clog2(NB);
    localparam int LOFF_W = $clog2(N_BYTES);
    localparam int WSEL_W = LOFF_W - BOFF_W;
    localparam int IDX_W  = $clog2(N_LINES);
    localparam int TAG_W  = PA_WIDTH - LOFF_W - IDX_W;

    typedef enum logic {ST_IDLE, ST_REFILL} state_e;

    state_e               state;
    logic [N_LINES-1:0]   valid;
    logic [TAG_W-1:0]     tags  [N_LINES];
    logic [LINE_W-1:0]    lines [N_LINES];
    logic [PA_WIDTH-1:0]  miss_pa;          // Address of the line in flight.

    logic [IDX_W-1:0]     idx;
    logic [IDX_W-1:0]     d_idx;
    logic [IDX_W-1:0]     m_idx;
    logic [WSEL_W-1:0]    d_wsel;
    logic                 tag_hit;
    logic                 d_hit;
    logic                 lookup;
    logic                 miss;
    logic [REG_WIDTH-1:0] word;
    logic [REG_WIDTH-1:0] shifted;

    assign idx     = i_pa[LOFF_W +: IDX_W];
    assign d_idx   = i_drain_addr[LOFF_W +: IDX_W];
    assign m_idx   = miss_pa[LOFF_W +: IDX_W];
    assign d_wsel  = i_drain_addr[BOFF_W +: WSEL_W];
    assign tag_hit = valid[idx] && (tags[idx] == i_pa[PA_WIDTH-1 -: TAG_W]);
    assign d_hit   = valid[d_idx] && (tags[d_idx] == i_drain_addr[PA_WIDTH-1 -: TAG_W]);

    assign lookup = i_load && !i_stb_hit;   // Forwarded loads skip the cache.
    assign miss   = lookup && !tag_hit;

    assign o_stall       = (state == ST_REFILL) || miss;
    assign o_drain_ready = (state == ST_IDLE) && !miss; // Keeps the memory port free.

    assign word    = lines[idx][i_pa[BOFF_W +: WSEL_W] * REG_WIDTH +: REG_WIDTH];
    assign shifted = word >> {i_pa[BOFF_W-1:0], 3'b000};

    always_comb begin
        case (i_control.size)
            dme_pkg::SIZE_BYTE:
                o_read_data = i_control.use_unsigned ? REG_WIDTH'(shifted[7:0])
                            : {{(REG_WIDTH - 8){shifted[7]}}, shifted[7:0]};
            dme_pkg::SIZE_HALF:
                o_read_data = i_control.use_unsigned ? REG_WIDTH'(shifted[15:0])
                            : {{(REG_WIDTH - 16){shifted[15]}}, shifted[15:0]};
            default:
                o_read_data = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state        <= ST_IDLE;
            valid        <= '0;
            o_mem_enable <= 1'b0;
        end else begin
            o_mem_enable <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_drain) begin
                        o_mem_enable <= 1'b1;
                    end else if (miss) begin
                        o_mem_enable <= 1'b1;
                        state        <= ST_REFILL;
                    end
                end
                default: begin
                    if (i_mem_enable) begin
                        valid[m_idx] <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Request payload that is valid with o_mem_enable.
    always_ff @(posedge clk) begin
        if (i_drain) begin
            o_mem_write  <= 1'b1;
            o_mem_addr   <= i_drain_addr;
            o_mem_data   <= i_drain_data;
            o_mem_strobe <= i_drain_strobe;
        end else if ((state == ST_IDLE) && miss) begin
            o_mem_write <= 1'b0;
            o_mem_addr  <= {i_pa[PA_WIDTH-1:LOFF_W], LOFF_W'(0)};
            miss_pa     <= i_pa;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_REFILL) && i_mem_enable) begin
            lines[m_idx] <= i_mem_data;
            tags[m_idx]  <= miss_pa[PA_WIDTH-1 -: TAG_W];
        end else if (i_drain && d_hit) begin
            for (int b = 0; b < NB; b++) begin
                if (i_drain_strobe[b]) begin
                    lines[d_idx][d_wsel * REG_WIDTH + 8 * b +: 8] <= i_drain_data[8 * b +: 8];
                end
            end
        end
    end

    // One memory transaction at a time around a refill.
    assert property (@(posedge clk) disable iff (i_reset)
        (state == ST_REFILL) |-> !i_drain);
    assert property (@(posedge clk) disable iff (i_reset)
        i_mem_enable |-> (state == ST_REFILL));

endmodule

// File: stb.sv
`timescale 1ns/1ns

module stb #(
    parameter int N_LINES   = 4,
    parameter int PA_WIDTH  = 32,
    parameter int REG_WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     i_reset,
    input  logic                     i_push,
    input  dme_pkg::mem_control_t    i_control,
    input  logic [PA_WIDTH-1:0]      i_pa,
    input  logic [REG_WIDTH-1:0]     i_write_data,
    input  logic                     i_load,
    input  logic                     i_drain_ready,
    output logic                     o_full_stall,
    output logic                     o_hit,
    output logic [REG_WIDTH-1:0]     o_read_data,
    output logic                     o_drain,
    output logic [PA_WIDTH-1:0]      o_drain_addr,
    output logic [REG_WIDTH-1:0]     o_drain_data,
    output logic [REG_WIDTH/8-1:0]   o_drain_strobe
);

    localparam int NB    = REG_WIDTH / 8;
    localparam int OFF_W = $clog2(NB);
    localparam int PTR_W = $clog2(N_LINES);
    localparam int CNT_W = $clog2(N_LINES + 1);

    logic [PA_WIDTH-1:0]  ent_addr [N_LINES];  // Word aligned.
    logic [REG_WIDTH-1:0] ent_data [N_LINES];  // Bytes sit in their lanes.
    logic [NB-1:0]        ent_strb [N_LINES];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 full;
    logic                 empty;
    logic [NB-1:0]        acc_mask;
    logic                 fwd_found;
    logic [PTR_W-1:0]     fwd_idx;
    logic                 covered;
    logic [REG_WIDTH-1:0] fwd_shift;

    assign full  = (count == CNT_W'(N_LINES));
    assign empty = (count == '0);

    // Byte lanes touched by the current access.
    always_comb begin
        logic [NB-1:0] base;
        case (i_control.size)
            dme_pkg::SIZE_BYTE: base = NB'(1);
            dme_pkg::SIZE_HALF: base = NB'(3);
            default:            base = '1;
        endcase
        acc_mask = base << i_pa[OFF_W-1:0];
    end

    // Walk oldest to youngest, so the last overlap found is the youngest.
    always_comb begin
        logic [PTR_W-1:0] idx;
        idx       = rd_ptr;
        fwd_found = 1'b0;
        fwd_idx   = rd_ptr;
        for (int k = 0; k < N_LINES; k++) begin
            if ((CNT_W'(k) < count) &&
                (ent_addr[idx][PA_WIDTH-1:OFF_W] == i_pa[PA_WIDTH-1:OFF_W]) &&
                (|(ent_strb[idx] & acc_mask))) begin
                fwd_found = 1'b1;
                fwd_idx   = idx;
            end
            idx = (idx == PTR_W'(N_LINES - 1)) ? '0 : idx + 1'b1;
        end
    end

    assign covered   = ((ent_strb[fwd_idx] & acc_mask) == acc_mask);
    assign o_hit     = i_load && fwd_found && covered;
    assign fwd_shift = ent_data[fwd_idx] >> {i_pa[OFF_W-1:0], 3'b000};

    // Partial overlap waits for the store to leave.
    assign o_full_stall = (full && i_control.is_store) || (i_load && fwd_found && !covered);

    always_comb begin
        case (i_control.size)
            dme_pkg::SIZE_BYTE:
                o_read_data = i_control.use_unsigned ? REG_WIDTH'(fwd_shift[7:0])
                            : {{(REG_WIDTH - 8){fwd_shift[7]}}, fwd_shift[7:0]};
            dme_pkg::SIZE_HALF:
                o_read_data = i_control.use_unsigned ? REG_WIDTH'(fwd_shift[15:0])
                            : {{(REG_WIDTH - 16){fwd_shift[15]}}, fwd_shift[15:0]};
            default:
                o_read_data = fwd_shift;
        endcase
    end

    // A new store takes the cycle, draining uses the idle ones.
    assign o_drain        = !empty && i_drain_ready && !i_push;
    assign o_drain_addr   = ent_addr[rd_ptr];
    assign o_drain_data   = ent_data[rd_ptr];
    assign o_drain_strobe = ent_strb[rd_ptr];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) wr_ptr <= (wr_ptr == PTR_W'(N_LINES - 1)) ? '0 : wr_ptr + 1'b1;
            if (o_drain) rd_ptr <= (rd_ptr == PTR_W'(N_LINES - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(i_push) - CNT_W'(o_drain);
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) begin
            ent_addr[wr_ptr] <= {i_pa[PA_WIDTH-1:OFF_W], OFF_W'(0)};
            ent_data[wr_ptr] <= i_write_data << {i_pa[OFF_W-1:0], 3'b000};
            ent_strb[wr_ptr] <= acc_mask;
        end
    end

    assert property (@(posedge clk) disable iff (i_reset) i_push |-> !full);
    assert property (@(posedge clk) disable iff (i_reset)
        (wr_ptr == rd_ptr) == (empty || full));

endmodule

// File: tlb.sv
`timescale 1ns/1ns

module tlb #(
    parameter int N_LINES  = 4,
    parameter int VA_WIDTH = 32,
    parameter int PA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_write_enable,
    input  logic [VA_WIDTH-1:0]   i_virtual_addr,
    input  logic [PA_WIDTH-1:0]   i_physical_addr,
    output logic [PA_WIDTH-1:0]   o_physical_addr,
    output logic                  o_exception
);

    localparam int OFF_W = dme_pkg::PAGE_BITS;
    localparam int VPN_W = VA_WIDTH - OFF_W;
    localparam int PPN_W = PA_WIDTH - OFF_W;
    localparam int PTR_W = $clog2(N_LINES);

    logic [N_LINES-1:0] valid;
    logic [VPN_W-1:0]   vpn [N_LINES];
    logic [PPN_W-1:0]   ppn [N_LINES];
    logic [PTR_W-1:0]   rr_ptr;            // Next victim for a new page.
    logic [N_LINES-1:0] match;
    logic [PPN_W-1:0]   hit_ppn;
    logic [PTR_W-1:0]   hit_idx;
    logic [PTR_W-1:0]   victim;

    always_comb begin
        hit_ppn = '0;
        hit_idx = '0;
        for (int i = 0; i < N_LINES; i++) begin
            match[i] = valid[i] && (vpn[i] == i_virtual_addr[VA_WIDTH-1:OFF_W]);
            if (match[i]) begin
                hit_ppn = ppn[i];
                hit_idx = PTR_W'(i);
            end
        end
    end

    assign victim          = (|match) ? hit_idx : rr_ptr; // Known page is overwritten.
    assign o_physical_addr = {hit_ppn, i_virtual_addr[OFF_W-1:0]};
    assign o_exception     = ~|match;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            valid  <= '0;
            rr_ptr <= '0;
        end else if (i_write_enable) begin
            valid[victim] <= 1'b1;
            if (!(|match)) begin
                rr_ptr <= (rr_ptr == PTR_W'(N_LINES - 1)) ? '0 : rr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_write_enable) begin
            vpn[victim] <= i_virtual_addr[VA_WIDTH-1:OFF_W];
            ppn[victim] <= i_physical_addr[PA_WIDTH-1:OFF_W];
        end
    end

    // A page never lives in two entries.
    for (genvar i = 0; i < N_LINES; i++) begin : g_uniq
        for (genvar j = i + 1; j < N_LINES; j++) begin : g_pair
            assert property (@(posedge clk) disable iff (i_reset)
                !(valid[i] && valid[j] && (vpn[i] == vpn[j])));
        end
    end

endmodule

// File: dme_pkg.sv
package dme_pkg;

    // Access size of a load or store.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // Control word that comes with each memory operation.
    typedef struct packed {
        logic      is_load;
        logic      is_store;
        mem_size_e size;
        logic      use_unsigned;   // Zero extension on loads.
    } mem_control_t;

    // Page offset width, the same for virtual and physical addresses.
    parameter int PAGE_BITS = 12;

endpackage
